// ==== bench/mem_asserts.sv ====
// Write queue protocol checks
// Bus request stability, FIFO occupancy and read ordering

module mem_asserts (
	input logic i_clock,
	input logic i_rst,
	input mem_pkg::bus_req_t i_bus,
	input logic i_bus_ready,
	input logic [mem_pkg::WB_PTR_W:0] i_count
);
	timeunit 1ns;
	timeprecision 100ps;

	// Held request keeps all fields until ready
	assert property (@(posedge i_clock) disable iff (i_rst)
		i_bus.request && !i_bus_ready |=> i_bus.request && $stable(i_bus))
	else $error("bus request or its fields changed before ready");

	assert property (@(posedge i_clock) disable iff (i_rst)
		int'(i_count) <= mem_pkg::WB_DEPTH)
	else $error("write queue count above its depth");

	// Reads only go out once posted writes have drained
	assert property (@(posedge i_clock) disable iff (i_rst)
		$rose(i_bus.request) && !i_bus.rw |-> i_count == '0)
	else $error("bus read started while writes were still queued");

endmodule

bind write_queue mem_asserts u_asserts (
	.i_clock(i_clock),
	.i_rst(i_rst),
	.i_bus(o_bus),
	.i_bus_ready(i_bus_ready),
	.i_count(count)
);

// ==== bench/mem_tb.sv ====
// Memory subsystem testbench
// Random-latency bus memory, shadow reference model and directed load/store tests

module mem_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int MEM_WORDS = 2048;
	localparam int TIMEOUT = 200;
	localparam logic [31:0] SEED = 32'h9bb7462f;
	localparam logic [31:0] CACHED_BASE = {mem_pkg::CACHED_NIBBLE, 28'h0};
	localparam logic [31:0] UNCACHED_BASE = 32'h1000_0000;

	logic i_clock = 1'b0;
	logic i_rst;
	mem_pkg::execute_data_t i_data;
	logic o_busy;
	mem_pkg::memory_data_t o_data;
	mem_pkg::bus_req_t o_bus;
	logic i_bus_ready;
	logic [31:0] i_bus_rdata;
	logic [31:0] o_dcache_hit;
	logic [31:0] o_dcache_miss;

	logic [31:0] bus_mem [MEM_WORDS];
	logic [31:0] shadow_mem [MEM_WORDS];
	logic [31:0] data_lfsr = SEED;
	logic [31:0] delay_lfsr = SEED;
	mem_pkg::memory_data_t expected_q [$];
	logic [31:0] next_pc = 32'h0000_1000;
	logic last_strobe = 1'b0;
	logic aborted = 1'b0;
	string test_name;
	int bus_wait = 0;
	int bus_requests = 0;
	int issued = 0;
	int completed = 0;
	int checks = 0;
	int errors = 0;
	int test_checks;
	int test_errors;

	always #2 i_clock = ~i_clock;

	mem_subsystem DUT (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_data(i_data),
		.o_busy(o_busy),
		.o_data(o_data),
		.o_bus(o_bus),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata),
		.o_dcache_hit(o_dcache_hit),
		.o_dcache_miss(o_dcache_miss)
	);

	// ==================================================
	// Helpers and reference model

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] lfsr_bits(inout logic [31:0] state, input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			value = {value[30:0], state[0]};
			state = state[0] ? ((state >> 1) ^ 32'hA300_0000) : (state >> 1);
		end
		return value;
	endfunction

	// One 4 KB window per region
	function automatic int mem_index(input logic [31:0] addr);
		return int'({addr[31:28] == mem_pkg::CACHED_NIBBLE, addr[11:2]});
	endfunction

	function automatic logic [31:0] address_of(input int idx);
		return (idx[10] ? CACHED_BASE : UNCACHED_BASE) | {20'h0, idx[9:0], 2'b00};
	endfunction

	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return {addr[15:0], addr[31:16]} ^ 32'h6d2b_79f5;
	endfunction

	function automatic logic [31:0] expected_rd(input mem_pkg::execute_data_t rec,
		input logic [31:0] word);
		logic [7:0] bytes [4];
		int lo;
		if (!rec.mem_read) begin
			return rec.rd;
		end
		for (int b = 0; b < 4; b++) begin
			bytes[b] = word[8 * b +: 8];
		end
		lo = int'(rec.mem_address[1:0]);
		if (rec.mem_width == mem_pkg::MEMW_1) begin
			return {{24{rec.mem_signed && bytes[lo][7]}}, bytes[lo]};
		end else if (rec.mem_width == mem_pkg::MEMW_2) begin
			return {{16{rec.mem_signed && bytes[lo + 1][7]}}, bytes[lo + 1], bytes[lo]};
		end
		return word;
	endfunction

	// Merge store data into a memory word byte by byte
	function automatic logic [31:0] merged_word(input mem_pkg::execute_data_t rec,
		input logic [31:0] word);
		logic [31:0] result;
		int nbytes;
		int lo;
		result = word;
		lo = int'(rec.mem_address[1:0]);
		nbytes = (rec.mem_width == mem_pkg::MEMW_1) ? 1
			: (rec.mem_width == mem_pkg::MEMW_2) ? 2 : 4;
		for (int b = 0; b < nbytes; b++) begin
			result[8 * (lo + b) +: 8] = rec.rd[8 * b +: 8];
		end
		return result;
	endfunction

	function automatic mem_pkg::execute_data_t new_record(input logic [31:0] addr,
		input logic [31:0] data);
		mem_pkg::execute_data_t rec;
		rec = '0;
		rec.pc = next_pc;
		rec.rd = data;
		rec.inst_rd = 5'(lfsr_bits(data_lfsr, 5));
		rec.mem_address = addr;
		rec.mem_width = mem_pkg::MEMW_4;
		next_pc = next_pc + 32'd4;
		return rec;
	endfunction

	task automatic compare_value(input string field, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		assert (actual === expected) else begin
			$display("ERROR %s %s: expected %h, actual %h", test_name, field, expected, actual);
			errors++;
		end
	endtask

	// Called on a falling edge, returns on a falling edge
	task automatic execute_record(input mem_pkg::execute_data_t rec);
		mem_pkg::memory_data_t exp;
		logic busy_exp;
		int idx;
		int waited;
		if (aborted) begin
			return;
		end
		idx = mem_index(rec.mem_address);
		busy_exp = rec.mem_read || rec.mem_write || rec.mem_flush;
		exp = '{strobe: 1'b0, pc: rec.pc, rd: expected_rd(rec, shadow_mem[idx]),
			inst_rd: rec.inst_rd};
		expected_q.push_back(exp);
		if (rec.mem_write) begin
			shadow_mem[idx] = merged_word(rec, shadow_mem[idx]);
		end
		rec.strobe = ~i_data.strobe;
		i_data = rec;
		issued++;
		waited = 0;
		while (completed < issued && waited < TIMEOUT) begin
			@(negedge i_clock);
			waited++;
			// Memory records are still pending one cycle after issue
			if (waited == 1) begin
				compare_value("busy", 32'(busy_exp), 32'(o_busy));
			end
		end
		if (completed < issued) begin
			$display("Timeout: pc %h did not complete within %0d cycles", rec.pc, TIMEOUT);
			errors++;
			aborted = 1'b1;
		end
	endtask

	task automatic load(input logic [31:0] addr, input mem_pkg::mem_width_t width,
		input logic sgn);
		mem_pkg::execute_data_t rec;
		rec = new_record(addr, lfsr_bits(data_lfsr, 32));
		rec.mem_read = 1'b1;
		rec.mem_width = width;
		rec.mem_signed = sgn;
		execute_record(rec);
	endtask

	task automatic store(input logic [31:0] addr, input mem_pkg::mem_width_t width,
		input logic [31:0] data);
		mem_pkg::execute_data_t rec;
		rec = new_record(addr, data);
		rec.mem_write = 1'b1;
		rec.mem_width = width;
		execute_record(rec);
	endtask

	task automatic flush_cache();
		mem_pkg::execute_data_t rec;
		rec = new_record(CACHED_BASE, lfsr_bits(data_lfsr, 32));
		rec.mem_flush = 1'b1;
		execute_record(rec);
	endtask

	task automatic start_section(input string name);
		test_name = name;
		test_checks = checks;
		test_errors = errors;
	endtask

	task automatic report_section();
		$display("%s: %0d checks, %0d errors", test_name, checks - test_checks,
			errors - test_errors);
	endtask

	// ==================================================
	// Bus memory and result checking

	always @(negedge i_clock) begin : bus_model
		int idx;
		i_bus_ready = 1'b0;
		if (i_rst) begin
			bus_wait = 0;
		end else if (o_bus.request) begin
			if (bus_wait == 0) begin
				bus_wait = 1 + int'(lfsr_bits(delay_lfsr, 2));
				bus_requests++;
				if (o_bus.address[27:12] != '0 || (o_bus.address[31:28] != 4'h1 &&
					o_bus.address[31:28] != mem_pkg::CACHED_NIBBLE)) begin
					$display("Bus request to address %h outside the modelled memory",
						o_bus.address);
					errors++;
				end
			end
			bus_wait--;
			if (bus_wait == 0) begin
				idx = mem_index(o_bus.address);
				i_bus_ready = 1'b1;
				if (o_bus.rw) begin
					bus_mem[idx] = o_bus.wdata;
				end else begin
					i_bus_rdata = bus_mem[idx];
				end
			end
		end
	end

	always @(negedge i_clock) begin : result_check
		mem_pkg::memory_data_t exp;
		if (!i_rst && o_data.strobe !== last_strobe) begin
			last_strobe = o_data.strobe;
			completed++;
			if (expected_q.size() == 0) begin
				$display("Result record with pc %h arrived with nothing outstanding", o_data.pc);
				errors++;
			end else begin
				exp = expected_q.pop_front();
				compare_value("pc", exp.pc, o_data.pc);
				compare_value("rd", exp.rd, o_data.rd);
				compare_value("inst_rd", 32'(exp.inst_rd), 32'(o_data.inst_rd));
				compare_value("busy after completion", 32'h0, 32'(o_busy));
			end
		end
	end

	// ==================================================
	// Tests

	task automatic word_round_trip();
		logic [31:0] addr;
		start_section("word_rw");
		for (int i = 0; i < 8; i++) begin
			addr = (i % 2 ? UNCACHED_BASE : CACHED_BASE) + 32'h40
				+ (lfsr_bits(data_lfsr, 4) << 2);
			store(addr, mem_pkg::MEMW_4, lfsr_bits(data_lfsr, 32));
			load(addr, mem_pkg::MEMW_4, 1'b0);
		end
		report_section();
	endtask

	task automatic subword_stores();
		logic [31:0] addr;
		mem_pkg::mem_width_t width;
		start_section("subword_st");
		for (int i = 0; i < 16; i++) begin
			addr = (i % 2 ? UNCACHED_BASE : CACHED_BASE) + 32'h100
				+ (lfsr_bits(data_lfsr, 2) << 2);
			width = lfsr_bits(data_lfsr, 1) ? mem_pkg::MEMW_2 : mem_pkg::MEMW_1;
			if (width == mem_pkg::MEMW_2) begin
				addr[1:0] = {1'(lfsr_bits(data_lfsr, 1)), 1'b0};
			end else begin
				addr[1:0] = 2'(lfsr_bits(data_lfsr, 2));
			end
			store(addr, width, lfsr_bits(data_lfsr, 32));
			load({addr[31:2], 2'b00}, mem_pkg::MEMW_4, 1'b0);
		end
		report_section();
	endtask

	task automatic subword_loads();
		logic [31:0] addr;
		start_section("subword_ld");
		for (int i = 0; i < 6; i++) begin
			addr = (i % 2 ? UNCACHED_BASE : CACHED_BASE) + 32'h200
				+ (lfsr_bits(data_lfsr, 5) << 2);
			store(addr, mem_pkg::MEMW_4, lfsr_bits(data_lfsr, 32));
			for (int lane = 0; lane < 4; lane++) begin
				load(addr + lane, mem_pkg::MEMW_1, 1'(lfsr_bits(data_lfsr, 1)));
			end
			load(addr, mem_pkg::MEMW_2, 1'(lfsr_bits(data_lfsr, 1)));
			load(addr + 2, mem_pkg::MEMW_2, 1'(lfsr_bits(data_lfsr, 1)));
		end
		report_section();
	endtask

	task automatic cache_counting();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] hit0;
		logic [31:0] miss0;
		start_section("counters");
		a = CACHED_BASE + 32'h400 + (lfsr_bits(data_lfsr, 6) << 2);
		b = a + mem_pkg::DCACHE_LINES * 4;
		hit0 = o_dcache_hit;
		miss0 = o_dcache_miss;
		repeat (4) load(a, mem_pkg::MEMW_4, 1'b0);
		compare_value("miss count", miss0 + 32'd1, o_dcache_miss);
		compare_value("hit count", hit0 + 32'd3, o_dcache_hit);
		hit0 = o_dcache_hit;
		miss0 = o_dcache_miss;
		repeat (2) load(UNCACHED_BASE + 32'h400, mem_pkg::MEMW_4, 1'b0);
		compare_value("uncached miss count", miss0, o_dcache_miss);
		compare_value("uncached hit count", hit0, o_dcache_hit);
		// Same line index, different tag
		store(a, mem_pkg::MEMW_4, lfsr_bits(data_lfsr, 32));
		load(b, mem_pkg::MEMW_4, 1'b0);
		store(b, mem_pkg::MEMW_4, lfsr_bits(data_lfsr, 32));
		load(a, mem_pkg::MEMW_4, 1'b0);
		load(b, mem_pkg::MEMW_4, 1'b0);
		report_section();
	endtask

	task automatic flush_and_refill();
		logic [31:0] addr;
		logic [31:0] hit0;
		logic [31:0] miss0;
		start_section("flush");
		addr = CACHED_BASE + 32'h600 + (lfsr_bits(data_lfsr, 6) << 2);
		load(addr, mem_pkg::MEMW_4, 1'b0);
		store(addr, mem_pkg::MEMW_4, lfsr_bits(data_lfsr, 32));
		load(addr, mem_pkg::MEMW_4, 1'b0);
		flush_cache();
		hit0 = o_dcache_hit;
		miss0 = o_dcache_miss;
		load(addr, mem_pkg::MEMW_4, 1'b0);
		compare_value("miss count", miss0 + 32'd1, o_dcache_miss);
		compare_value("hit count", hit0, o_dcache_hit);
		report_section();
	endtask

	task automatic non_memory_pass();
		int requests0;
		start_section("non_memory");
		// A read leaves the write queue empty
		load(UNCACHED_BASE, mem_pkg::MEMW_4, 1'b0);
		requests0 = bus_requests;
		execute_record(new_record(lfsr_bits(data_lfsr, 32), lfsr_bits(data_lfsr, 32)));
		compare_value("bus requests", 32'(requests0), 32'(bus_requests));
		report_section();
	endtask

	initial begin
		i_rst = 1'b1;
		i_data = '0;
		i_bus_ready = 1'b0;
		i_bus_rdata = '0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			bus_mem[i] = fill_word(address_of(i));
			shadow_mem[i] = bus_mem[i];
		end
		repeat (16) @(posedge i_clock);
		@(negedge i_clock);
		i_rst = 1'b0;

		word_round_trip();
		subword_stores();
		subword_loads();
		cache_counting();
		flush_and_refill();
		non_memory_pass();

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0 && expected_q.size() == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== logic/dcache.sv ====
// Direct-mapped write-through data cache
// One word per line, flush clears all lines, counts read hits and misses

module dcache (
	input logic i_clock,
	input logic i_rst,

	input mem_pkg::bus_req_t i_req,
	input logic i_flush,
	output logic o_ready,
	output logic [31:0] o_rdata,

	output mem_pkg::bus_req_t o_req,
	input logic i_ready,
	input logic [31:0] i_rdata,

	output logic [31:0] o_hit,
	output logic [31:0] o_miss
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RESPOND,
		ST_FORWARD
	} state_t;

	state_t state;
	logic [mem_pkg::DCACHE_LINES-1:0] valid;
	logic [31:0] hit_count;
	logic [31:0] miss_count;

	logic [mem_pkg::DCACHE_TAG_W-1:0] tag_mem [mem_pkg::DCACHE_LINES];
	logic [31:0] data_mem [mem_pkg::DCACHE_LINES];
	logic [31:0] resp_rdata;

	logic [mem_pkg::DCACHE_INDEX_W-1:0] index;
	logic [mem_pkg::DCACHE_TAG_W-1:0] tag;
	logic cacheable;
	logic line_hit;
	logic lookup;
	logic fwd_done;

	// ==================================================
	// Lookup

	assign index = i_req.address[mem_pkg::DCACHE_INDEX_W+1:2];
	assign tag = i_req.address[31:mem_pkg::DCACHE_INDEX_W+2];
	assign cacheable = i_req.address[31:28] == mem_pkg::CACHED_NIBBLE;
	assign line_hit = valid[index] && (tag_mem[index] == tag);

	// Cacheable read seen in idle
	assign lookup = (state == ST_IDLE) && i_req.request && !i_flush && !i_req.rw && cacheable;
	assign fwd_done = (state == ST_FORWARD) && i_ready;

	// ==================================================
	// Control

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state <= ST_IDLE;
			valid <= '0;
			hit_count <= '0;
			miss_count <= '0;
		end else begin
			unique case (state)
				ST_IDLE: begin
					if (i_req.request) begin
						if (i_flush) begin
							valid <= '0;
							state <= ST_RESPOND;
						end else if (lookup && line_hit) begin
							state <= ST_RESPOND;
						end else begin
							state <= ST_FORWARD;
						end
					end
				end
				ST_RESPOND: state <= ST_IDLE;
				ST_FORWARD: begin
					if (i_ready) begin
						// Read misses allocate, writes never do
						if (cacheable && !i_req.rw) begin
							valid[index] <= 1'b1;
						end
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase

			if (lookup && line_hit) begin
				hit_count <= hit_count + 32'd1;
			end
			if (lookup && !line_hit) begin
				miss_count <= miss_count + 32'd1;
			end
		end
	end

	// Line arrays
	always_ff @(posedge i_clock) begin
		if (lookup) begin
			resp_rdata <= data_mem[index];
		end
		if (fwd_done && cacheable && (!i_req.rw || line_hit)) begin
			tag_mem[index] <= tag;
			data_mem[index] <= i_req.rw ? i_req.wdata : i_rdata;
		end
	end

	// ==================================================
	// Responses

	assign o_ready = (state == ST_RESPOND) || fwd_done;
	assign o_rdata = (state == ST_FORWARD) ? i_rdata : resp_rdata;

	assign o_req = '{
		request: state == ST_FORWARD,
		rw: i_req.rw,
		address: i_req.address,
		wdata: i_req.wdata
	};

	assign o_hit = hit_count;
	assign o_miss = miss_count;

endmodule

// ==== logic/mem_pkg.sv ====
// Memory stage shared types
// Pipeline records, internal bus request, access width codes and sizes

package mem_pkg;

	// ==================================================
	// Sizes

	localparam int DCACHE_LINES = 64;
	localparam int DCACHE_INDEX_W = $clog2(DCACHE_LINES);
	localparam int DCACHE_TAG_W = 30 - DCACHE_INDEX_W;

	localparam int WB_DEPTH = 4;
	localparam int WB_PTR_W = $clog2(WB_DEPTH);

	// Top address nibble of the cacheable region
	localparam logic [3:0] CACHED_NIBBLE = 4'h2;

	// ==================================================
	// Types

	typedef enum logic [1:0] {
		MEMW_1 = 2'd0,
		MEMW_2 = 2'd1,
		MEMW_4 = 2'd2
	} mem_width_t;

	typedef struct packed {
		logic strobe;
		logic [31:0] pc;
		logic [31:0] rd;
		logic [4:0] inst_rd;
		logic mem_read;
		logic mem_write;
		logic mem_flush;
		mem_width_t mem_width;
		logic mem_signed;
		logic [31:0] mem_address;
	} execute_data_t;

	typedef struct packed {
		logic strobe;
		logic [31:0] pc;
		logic [31:0] rd;
		logic [4:0] inst_rd;
	} memory_data_t;

	// rw high means write, address always word aligned
	typedef struct packed {
		logic request;
		logic rw;
		logic [31:0] address;
		logic [31:0] wdata;
	} bus_req_t;

endpackage

// ==== logic/mem_stage.sv ====
// Memory pipeline stage
// Sequences loads, stores and flushes toward the data cache

module mem_stage (
	input logic i_clock,
	input logic i_rst,

	input mem_pkg::execute_data_t i_data,
	output logic o_busy,
	output mem_pkg::memory_data_t o_data,

	output mem_pkg::bus_req_t o_req,
	output logic o_flush,
	input logic i_ready,
	input logic [31:0] i_rdata
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_READ,
		ST_WRITE_WORD,
		ST_RMW_READ,
		ST_RMW_WRITE,
		ST_FLUSH
	} state_t;

	state_t state;
	logic last_strobe;
	logic out_strobe;
	logic req_request;
	logic req_rw;
	logic flush;

	logic [31:0] out_pc;
	logic [31:0] out_rd;
	logic [4:0] out_inst_rd;
	logic [31:0] req_wdata;

	logic pending;
	logic is_mem;
	logic done;
	logic [1:0] lane;
	logic [31:0] lane_data;
	logic [31:0] load_value;

	// Insert a byte or half into its lane of an aligned word
	function automatic logic [31:0] merge_lane(
		input logic [31:0] word,
		input logic [31:0] value,
		input mem_pkg::mem_width_t width,
		input logic [1:0] lane_sel
	);
		logic [31:0] mask;
		logic [4:0] shift;
		mask = (width == mem_pkg::MEMW_1) ? 32'h0000_00ff : 32'h0000_ffff;
		shift = {lane_sel, 3'b000};
		return (word & ~(mask << shift)) | ((value & mask) << shift);
	endfunction

	// ==================================================
	// Decode and load extraction

	assign pending = i_data.strobe != last_strobe;
	assign is_mem = i_data.mem_read || i_data.mem_write || i_data.mem_flush;
	assign o_busy = pending && is_mem;

	assign lane = i_data.mem_address[1:0];
	assign lane_data = i_rdata >> {lane, 3'b000};

	always_comb begin
		unique case (i_data.mem_width)
			mem_pkg::MEMW_1:
				load_value = {{24{i_data.mem_signed & lane_data[7]}}, lane_data[7:0]};
			mem_pkg::MEMW_2:
				load_value = {{16{i_data.mem_signed & lane_data[15]}}, lane_data[15:0]};
			default:
				load_value = i_rdata;
		endcase
	end

	always_comb begin
		unique case (state)
			ST_IDLE: done = pending && !is_mem;
			ST_READ, ST_WRITE_WORD, ST_FLUSH: done = i_ready;
			ST_RMW_WRITE: done = i_ready && req_request;
			default: done = 1'b0;
		endcase
	end

	// ==================================================
	// Sequencer

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state <= ST_IDLE;
			last_strobe <= 1'b0;
			out_strobe <= 1'b0;
			req_request <= 1'b0;
			req_rw <= 1'b0;
			flush <= 1'b0;
		end else begin
			if (done) begin
				out_strobe <= ~out_strobe;
				last_strobe <= i_data.strobe;
			end
			unique case (state)
				ST_IDLE: begin
					if (pending && i_data.mem_read) begin
						req_request <= 1'b1;
						state <= ST_READ;
					end else if (pending && i_data.mem_write) begin
						req_request <= 1'b1;
						if (i_data.mem_width == mem_pkg::MEMW_4) begin
							req_rw <= 1'b1;
							state <= ST_WRITE_WORD;
						end else begin
							state <= ST_RMW_READ;
						end
					end else if (pending && i_data.mem_flush) begin
						req_request <= 1'b1;
						flush <= 1'b1;
						state <= ST_FLUSH;
					end
				end
				ST_READ, ST_WRITE_WORD, ST_FLUSH: begin
					if (i_ready) begin
						req_request <= 1'b0;
						req_rw <= 1'b0;
						flush <= 1'b0;
						state <= ST_IDLE;
					end
				end
				ST_RMW_READ: begin
					if (i_ready) begin
						req_request <= 1'b0;
						state <= ST_RMW_WRITE;
					end
				end
				ST_RMW_WRITE: begin
					// Merged word is ready after one idle cycle
					if (!req_request) begin
						req_request <= 1'b1;
						req_rw <= 1'b1;
					end else if (i_ready) begin
						req_request <= 1'b0;
						req_rw <= 1'b0;
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Result record and store data
	always_ff @(posedge i_clock) begin
		if (done) begin
			out_pc <= i_data.pc;
			out_rd <= (state == ST_READ) ? load_value : i_data.rd;
			out_inst_rd <= i_data.inst_rd;
		end
		if (state == ST_IDLE) begin
			req_wdata <= i_data.rd;
		end else if (state == ST_RMW_READ && i_ready) begin
			req_wdata <= merge_lane(i_rdata, i_data.rd, i_data.mem_width, lane);
		end
	end

	assign o_data = '{strobe: out_strobe, pc: out_pc, rd: out_rd, inst_rd: out_inst_rd};

	assign o_req = '{
		request: req_request,
		rw: req_rw,
		address: {i_data.mem_address[31:2], 2'b00},
		wdata: req_wdata
	};
	assign o_flush = flush;

endmodule

// ==== logic/mem_subsystem.sv ====
// Memory subsystem top level
// Chains the memory stage, data cache and write queue to the bus port

module mem_subsystem (
	input logic i_clock,
	input logic i_rst,

	input mem_pkg::execute_data_t i_data,
	output logic o_busy,
	output mem_pkg::memory_data_t o_data,

	output mem_pkg::bus_req_t o_bus,
	input logic i_bus_ready,
	input logic [31:0] i_bus_rdata,

	output logic [31:0] o_dcache_hit,
	output logic [31:0] o_dcache_miss
);

	// Stage to cache
	mem_pkg::bus_req_t stage_req;
	logic stage_flush;
	logic stage_ready;
	logic [31:0] stage_rdata;

	// Cache to queue
	mem_pkg::bus_req_t cache_req;
	logic cache_ready;
	logic [31:0] cache_rdata;

	mem_stage u_stage (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_data(i_data),
		.o_busy(o_busy),
		.o_data(o_data),
		.o_req(stage_req),
		.o_flush(stage_flush),
		.i_ready(stage_ready),
		.i_rdata(stage_rdata)
	);

	dcache u_dcache (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_req(stage_req),
		.i_flush(stage_flush),
		.o_ready(stage_ready),
		.o_rdata(stage_rdata),
		.o_req(cache_req),
		.i_ready(cache_ready),
		.i_rdata(cache_rdata),
		.o_hit(o_dcache_hit),
		.o_miss(o_dcache_miss)
	);

	write_queue u_queue (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_req(cache_req),
		.o_ready(cache_ready),
		.o_rdata(cache_rdata),
		.o_bus(o_bus),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata)
	);

endmodule

// ==== logic/write_queue.sv ====
// Posted-write FIFO in front of the external bus
// Writes drain in order, reads wait until the FIFO is empty

module write_queue (
	input logic i_clock,
	input logic i_rst,

	input mem_pkg::bus_req_t i_req,
	output logic o_ready,
	output logic [31:0] o_rdata,

	output mem_pkg::bus_req_t o_bus,
	input logic i_bus_ready,
	input logic [31:0] i_bus_rdata
);

	mem_pkg::bus_req_t fifo_mem [mem_pkg::WB_DEPTH];
	logic [mem_pkg::WB_PTR_W-1:0] head;
	logic [mem_pkg::WB_PTR_W-1:0] tail;
	logic [mem_pkg::WB_PTR_W:0] count;

	logic bus_request;
	mem_pkg::bus_req_t bus_hold;

	logic full;
	logic empty;
	logic push;
	logic pop;
	logic bus_done;
	logic read_wait;

	assign full = count == (mem_pkg::WB_PTR_W + 1)'(mem_pkg::WB_DEPTH);
	assign empty = count == '0;
	assign push = i_req.request && i_req.rw && !full;
	assign bus_done = bus_request && i_bus_ready;
	assign pop = bus_done && bus_hold.rw;
	assign read_wait = i_req.request && !i_req.rw;

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			bus_request <= 1'b0;
		end else begin
			if (push) begin
				tail <= tail + 1'b1;
			end
			if (pop) begin
				head <= head + 1'b1;
			end
			unique case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// One idle cycle on the bus after every completed request
			if (bus_request) begin
				if (i_bus_ready) begin
					bus_request <= 1'b0;
				end
			end else if (!empty || read_wait) begin
				bus_request <= 1'b1;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (push) begin
			fifo_mem[tail] <= i_req;
		end
		if (!bus_request) begin
			bus_hold <= empty ? i_req : fifo_mem[head];
		end
	end

	always_comb begin
		o_bus = bus_hold;
		o_bus.request = bus_request;
	end

	assign o_ready = push || (bus_done && !bus_hold.rw);
	assign o_rdata = i_bus_rdata;

endmodule

// ==== vlog.f ====
logic/mem_pkg.sv
logic/mem_stage.sv
logic/dcache.sv
logic/write_queue.sv
logic/mem_subsystem.sv
bench/mem_asserts.sv
bench/mem_tb.sv
